// File: rtl/vlsu_pkg.sv
// Shared constants, types and bus structs of the vector load/store unit.
// Every RTL block and the testbench import this package.

package vlsu_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Data word
  localparam int unsigned ELEN  = 32;
  localparam int unsigned ELENB = ELEN / 8;

  // Register file geometry
  localparam int unsigned VELE            = 8;
  localparam int unsigned NR_VREGS        = 32;
  localparam int unsigned VREG_ADDR_WIDTH = $clog2(NR_VREGS * VELE);

  // Reorder buffer depth and tag width
  localparam int unsigned NR_OUTSTANDING_LOADS = 8;
  localparam int unsigned ID_WIDTH             = $clog2(NR_OUTSTANDING_LOADS);

  //////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////

  typedef logic [ELEN-1:0]            elen_t;
  typedef logic [ELENB-1:0]           strb_t;
  typedef logic [ID_WIDTH-1:0]        id_t;
  typedef logic [ID_WIDTH:0]          rob_cnt_t;
  typedef logic [5:0]                 vlen_t;
  typedef logic [VREG_ADDR_WIDTH-1:0] vreg_addr_t;

  typedef enum logic {
    VLE = 1'b0,
    VSE = 1'b1
  } vlsu_op_e;

  typedef enum logic {
    ALU = 1'b0,
    LSU = 1'b1
  } ex_unit_e;

  // Element width, also used as the memory access size
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  // vl counts elements on the request port, bytes once captured
  typedef struct packed {
    ex_unit_e   ex_unit;
    vlsu_op_e   op;
    logic [4:0] vd;
    elen_t      rs1;
    vlen_t      vl;
    vew_e       vsew;
  } vlsu_req_t;

  typedef struct packed {
    id_t   id;
    elen_t addr;
    logic  we;
    vew_e  size;
    strb_t strb;
    elen_t wdata;
    logic  last;
  } mem_req_t;

  typedef struct packed {
    id_t   id;
    elen_t rdata;
  } mem_result_t;

endpackage

// File: rtl/vlsu_req_ctrl.sv
// Request front end of the load/store unit. Accepts one LSU instruction
// at a time, keeps it for the whole operation with vl turned into bytes,
// and signals ready once both byte counters have drained.

`timescale 1ns/1ps

module vlsu_req_ctrl (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  vlsu_pkg::vlsu_req_t  vlsu_req_i,
  input  logic                 vlsu_req_valid_i,
  input  logic                 mem_busy_i,
  input  logic                 vreg_busy_i,
  output logic                 vlsu_req_ready_o,
  output logic                 new_req_o,
  output vlsu_pkg::vlsu_req_t  req_q_o
);

  import vlsu_pkg::*;

  vlsu_req_t req_d, req_q;

  // Idle when neither side has bytes left
  assign vlsu_req_ready_o = ~mem_busy_i & ~vreg_busy_i;

  // Instructions for other units pass by
  assign new_req_o = vlsu_req_valid_i & vlsu_req_ready_o & (vlsu_req_i.ex_unit == LSU);

  always_comb begin
    req_d = req_q;

    if (new_req_o) begin
      req_d = vlsu_req_i;
      // Elements to bytes
      unique case (vlsu_req_i.vsew)
        EW_8:    req_d.vl = vlsu_req_i.vl;
        EW_16:   req_d.vl = vlsu_req_i.vl << 1;
        EW_32:   req_d.vl = vlsu_req_i.vl << 2;
        default: req_d.vl = '0;
      endcase
    end else if (vlsu_req_ready_o && (req_q.vl != '0)) begin
      // Operation drained, drop it
      req_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= '0;
    end else begin
      req_q <= req_d;
    end
  end

  assign req_q_o = req_q;

endmodule

// File: rtl/vlsu_byte_counter.sv
// Byte progress counter for one side of a transfer. Advances by a word,
// or by the tail of the operation, each time its step is granted, and
// reports the byte enables of the word currently in flight.

`timescale 1ns/1ps

module vlsu_byte_counter (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            clear_i,
  input  logic            step_i,
  input  vlsu_pkg::vlen_t total_i,
  output vlsu_pkg::vlen_t count_o,
  output logic            valid_o,
  output logic            last_o,
  output vlsu_pkg::strb_t be_o
);

  import vlsu_pkg::*;

  vlen_t count_q;
  vlen_t remaining;
  vlen_t delta;

  // Stays quiet once total drops below the old count
  assign valid_o   = count_q < total_i;
  assign remaining = total_i - count_q;
  assign last_o    = valid_o && (remaining <= vlen_t'(ELENB));

  // Full word, or only what is left on the last one
  assign delta = last_o ? remaining : vlen_t'(ELENB);

  always_comb begin
    for (int unsigned k = 0; k < ELENB; k++) begin
      be_o[k] = valid_o && (vlen_t'(k) < delta);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (step_i && valid_o) begin
      count_q <= count_q + delta;
    end
  end

  assign count_o = count_q;

endmodule

// File: rtl/vlsu_reorder_buffer.sv
// Tagged reorder buffer. Ids are handed out in order, entries are
// written by id in any order, and the head only leaves once its own
// entry has arrived, so the output order matches the allocation order.

`timescale 1ns/1ps

module vlsu_reorder_buffer (
  input  logic            clk_i,
  input  logic            arst_n_i,
  // Id allocation
  input  logic            alloc_i,
  output vlsu_pkg::id_t   alloc_id_o,
  // Write by id
  input  logic            push_i,
  input  vlsu_pkg::id_t   push_id_i,
  input  vlsu_pkg::elen_t push_data_i,
  // In-order read
  input  logic            pop_i,
  output logic            head_valid_o,
  output vlsu_pkg::elen_t head_data_o,
  output vlsu_pkg::id_t   head_id_o,
  output logic            full_o,
  output logic            empty_o
);

  import vlsu_pkg::*;

  elen_t                           data_q [NR_OUTSTANDING_LOADS];
  logic [NR_OUTSTANDING_LOADS-1:0] valid_q;
  id_t                             wr_ptr_q;
  id_t                             rd_ptr_q;
  rob_cnt_t                        count_q;

  logic alloc_en;
  logic pop_en;

  assign full_o  = count_q == rob_cnt_t'(NR_OUTSTANDING_LOADS);
  assign empty_o = count_q == '0;

  assign alloc_id_o   = wr_ptr_q;
  assign head_id_o    = rd_ptr_q;
  assign head_valid_o = valid_q[rd_ptr_q];
  assign head_data_o  = data_q[rd_ptr_q];

  // No allocation when full, no pop before the head has landed
  assign alloc_en = alloc_i & ~full_o;
  assign pop_en   = pop_i & head_valid_o;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[push_id_i] <= push_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Pointers, flags and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      valid_q  <= '0;
      count_q  <= '0;
    end else begin
      if (alloc_en) begin
        wr_ptr_q <= wr_ptr_q + id_t'(1);
      end
      if (pop_en) begin
        rd_ptr_q          <= rd_ptr_q + id_t'(1);
        valid_q[rd_ptr_q] <= 1'b0;
      end
      // Push and pop never hit the same slot
      if (push_i) begin
        valid_q[push_id_i] <= 1'b1;
      end
      unique case ({alloc_en, pop_en})
        2'b10:   count_q <= count_q + rob_cnt_t'(1);
        2'b01:   count_q <= count_q - rob_cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: rtl/vlsu_datapath.sv
// Steering logic of the load/store unit. Loads go memory -> reorder
// buffer -> register file, stores go register file -> buffer -> memory.
// Builds the memory request and the register file addresses.

`timescale 1ns/1ps

module vlsu_datapath (
  input  vlsu_pkg::vlsu_req_t   req_q_i,
  // Byte counters
  input  vlsu_pkg::vlen_t       mem_count_i,
  input  vlsu_pkg::vlen_t       vreg_count_i,
  input  logic                  mem_valid_i,
  input  logic                  vreg_valid_i,
  input  logic                  mem_last_i,
  input  vlsu_pkg::strb_t       mem_be_i,
  input  vlsu_pkg::strb_t       vreg_be_i,
  output logic                  mem_step_o,
  output logic                  vreg_step_o,
  // Reorder buffer
  input  vlsu_pkg::id_t         rob_alloc_id_i,
  input  logic                  rob_head_valid_i,
  input  vlsu_pkg::elen_t       rob_head_data_i,
  input  vlsu_pkg::id_t         rob_head_id_i,
  input  logic                  rob_full_i,
  input  logic                  rob_empty_i,
  output logic                  rob_alloc_o,
  output logic                  rob_push_o,
  output vlsu_pkg::id_t         rob_push_id_o,
  output vlsu_pkg::elen_t       rob_push_data_o,
  output logic                  rob_pop_o,
  // Memory
  output vlsu_pkg::mem_req_t    mem_req_o,
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  input  vlsu_pkg::mem_result_t mem_result_i,
  input  logic                  mem_result_valid_i,
  // Register file
  output vlsu_pkg::vreg_addr_t  vrf_waddr_o,
  output vlsu_pkg::elen_t       vrf_wdata_o,
  output vlsu_pkg::strb_t       vrf_wbe_o,
  output logic                  vrf_we_o,
  input  logic                  vrf_wvalid_i,
  output vlsu_pkg::vreg_addr_t  vrf_raddr_o,
  output logic                  vrf_re_o,
  input  vlsu_pkg::elen_t       vrf_rdata_i,
  input  logic                  vrf_rvalid_i
);

  import vlsu_pkg::*;

  logic       is_load;
  logic       head_ready;
  elen_t      mem_addr;
  vreg_addr_t vreg_addr;

  assign is_load    = req_q_i.op == VLE;
  assign head_ready = rob_head_valid_i & ~rob_empty_i;

  // Word address in memory, word index within vd
  assign mem_addr  = req_q_i.rs1 + elen_t'(mem_count_i);
  assign vreg_addr = {req_q_i.vd, {$clog2(VELE){1'b0}}} +
                     vreg_addr_t'(vreg_count_i >> $clog2(ELENB));

  //////////////////////////////////////////////////
  // Load and store steering
  //////////////////////////////////////////////////

  always_comb begin
    mem_valid_o     = 1'b0;
    vrf_we_o        = 1'b0;
    vrf_re_o        = 1'b0;
    rob_alloc_o     = 1'b0;
    rob_push_o      = 1'b0;
    rob_push_id_o   = mem_result_i.id;
    rob_push_data_o = mem_result_i.rdata;
    rob_pop_o       = 1'b0;

    if (is_load) begin
      // Issue while bytes remain and a tag is free
      mem_valid_o = mem_valid_i & ~rob_full_i;
      rob_alloc_o = mem_valid_o & mem_ready_i;
      // Results land by their tag
      rob_push_o  = mem_result_valid_i;
      // Head goes to the register file in order
      vrf_we_o    = vreg_valid_i & head_ready;
      rob_pop_o   = vrf_we_o & vrf_wvalid_i;
    end else begin
      // Prefetch register words while there is room
      vrf_re_o        = vreg_valid_i & ~rob_full_i;
      rob_push_o      = vrf_re_o & vrf_rvalid_i;
      rob_alloc_o     = rob_push_o;
      rob_push_id_o   = rob_alloc_id_i;
      rob_push_data_o = vrf_rdata_i;
      // Head word goes out to memory
      mem_valid_o     = mem_valid_i & head_ready;
      rob_pop_o       = mem_valid_o & mem_ready_i;
    end
  end

  assign mem_step_o  = mem_valid_o & mem_ready_i;
  assign vreg_step_o = is_load ? (vrf_we_o & vrf_wvalid_i) : (vrf_re_o & vrf_rvalid_i);

  // Memory request
  always_comb begin
    mem_req_o.id    = is_load ? rob_alloc_id_i : rob_head_id_i;
    mem_req_o.addr  = {mem_addr[ELEN-1:2], 2'b00};
    mem_req_o.we    = ~is_load;
    mem_req_o.size  = req_q_i.vsew;
    mem_req_o.strb  = mem_be_i;
    mem_req_o.wdata = is_load ? '0 : rob_head_data_i;
    mem_req_o.last  = mem_last_i;
  end

  // Register file
  assign vrf_waddr_o = vreg_addr;
  assign vrf_raddr_o = vreg_addr;
  assign vrf_wdata_o = rob_head_data_i;
  assign vrf_wbe_o   = vreg_be_i;

endmodule

// File: rtl/vlsu.sv
// Vector load/store unit top level. Unit-stride loads and stores between
// a 32-bit memory port and the vector register file, with in-order
// write-back of out-of-order load results.

`timescale 1ns/1ps

module vlsu (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Instruction request
  input  vlsu_pkg::vlsu_req_t   vlsu_req_i,
  input  logic                  vlsu_req_valid_i,
  output logic                  vlsu_req_ready_o,
  // Memory
  output vlsu_pkg::mem_req_t    mem_req_o,
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  input  vlsu_pkg::mem_result_t mem_result_i,
  input  logic                  mem_result_valid_i,
  // Register file
  output vlsu_pkg::vreg_addr_t  vrf_waddr_o,
  output vlsu_pkg::vreg_addr_t  vrf_raddr_o,
  output vlsu_pkg::elen_t       vrf_wdata_o,
  output vlsu_pkg::strb_t       vrf_wbe_o,
  output logic                  vrf_we_o,
  output logic                  vrf_re_o,
  input  logic                  vrf_wvalid_i,
  input  logic                  vrf_rvalid_i,
  input  vlsu_pkg::elen_t       vrf_rdata_i
);

  import vlsu_pkg::*;

  vlsu_req_t req_q;
  logic      new_req;

  vlen_t mem_count, vreg_count;
  logic  mem_valid, vreg_valid, mem_last;
  strb_t mem_be, vreg_be;
  logic  mem_step, vreg_step;

  id_t   rob_alloc_id, rob_head_id, rob_push_id;
  elen_t rob_head_data, rob_push_data;
  logic  rob_head_valid, rob_full, rob_empty;
  logic  rob_alloc, rob_push, rob_pop;

  //////////////////////////////////////////////////
  // Request control and byte counters
  //////////////////////////////////////////////////

  vlsu_req_ctrl i_req_ctrl (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .vlsu_req_i      (vlsu_req_i),
    .vlsu_req_valid_i(vlsu_req_valid_i),
    .mem_busy_i      (mem_valid),
    .vreg_busy_i     (vreg_valid),
    .vlsu_req_ready_o(vlsu_req_ready_o),
    .new_req_o       (new_req),
    .req_q_o         (req_q)
  );

  vlsu_byte_counter i_mem_counter (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .clear_i (new_req),
    .step_i  (mem_step),
    .total_i (req_q.vl),
    .count_o (mem_count),
    .valid_o (mem_valid),
    .last_o  (mem_last),
    .be_o    (mem_be)
  );

  // Register side needs no last flag
  vlsu_byte_counter i_vreg_counter (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .clear_i (new_req),
    .step_i  (vreg_step),
    .total_i (req_q.vl),
    .count_o (vreg_count),
    .valid_o (vreg_valid),
    .last_o  (),
    .be_o    (vreg_be)
  );

  //////////////////////////////////////////////////
  // Reorder buffer and steering
  //////////////////////////////////////////////////

  vlsu_reorder_buffer i_reorder_buffer (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .alloc_i     (rob_alloc),
    .alloc_id_o  (rob_alloc_id),
    .push_i      (rob_push),
    .push_id_i   (rob_push_id),
    .push_data_i (rob_push_data),
    .pop_i       (rob_pop),
    .head_valid_o(rob_head_valid),
    .head_data_o (rob_head_data),
    .head_id_o   (rob_head_id),
    .full_o      (rob_full),
    .empty_o     (rob_empty)
  );

  vlsu_datapath i_datapath (
    .req_q_i           (req_q),
    .mem_count_i       (mem_count),
    .vreg_count_i      (vreg_count),
    .mem_valid_i       (mem_valid),
    .vreg_valid_i      (vreg_valid),
    .mem_last_i        (mem_last),
    .mem_be_i          (mem_be),
    .vreg_be_i         (vreg_be),
    .mem_step_o        (mem_step),
    .vreg_step_o       (vreg_step),
    .rob_alloc_id_i    (rob_alloc_id),
    .rob_head_valid_i  (rob_head_valid),
    .rob_head_data_i   (rob_head_data),
    .rob_head_id_i     (rob_head_id),
    .rob_full_i        (rob_full),
    .rob_empty_i       (rob_empty),
    .rob_alloc_o       (rob_alloc),
    .rob_push_o        (rob_push),
    .rob_push_id_o     (rob_push_id),
    .rob_push_data_o   (rob_push_data),
    .rob_pop_o         (rob_pop),
    .mem_req_o         (mem_req_o),
    .mem_valid_o       (mem_valid_o),
    .mem_ready_i       (mem_ready_i),
    .mem_result_i      (mem_result_i),
    .mem_result_valid_i(mem_result_valid_i),
    .vrf_waddr_o       (vrf_waddr_o),
    .vrf_wdata_o       (vrf_wdata_o),
    .vrf_wbe_o         (vrf_wbe_o),
    .vrf_we_o          (vrf_we_o),
    .vrf_wvalid_i      (vrf_wvalid_i),
    .vrf_raddr_o       (vrf_raddr_o),
    .vrf_re_o          (vrf_re_o),
    .vrf_rdata_i       (vrf_rdata_i),
    .vrf_rvalid_i      (vrf_rvalid_i)
  );

endmodule

// File: sim/tb_vlsu.sv
// Testbench for the vector load/store unit. Models a sparse memory with random
// ready and out-of-order load results, and a register file with random
// acknowledges, then checks every transfer and the final contents.

`timescale 1ns/1ps

module tb_vlsu;

  import vlsu_pkg::*;

  localparam int unsigned SEED           = 80274;
  localparam int unsigned NUM_RANDOM_OPS = 10;
  localparam int unsigned NUM_OPS        = 20;
  localparam int unsigned CYCLES_PER_OP  = 64;
  localparam int unsigned TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP;

  logic        clk_i = 1'b0;
  logic        arst_n_i;
  vlsu_req_t   vlsu_req_i;
  logic        vlsu_req_valid_i;
  logic        vlsu_req_ready_o;
  mem_req_t    mem_req_o;
  logic        mem_valid_o;
  logic        mem_ready_i = 1'b0;
  mem_result_t mem_result_i = '0;
  logic        mem_result_valid_i = 1'b0;
  vreg_addr_t  vrf_waddr_o, vrf_raddr_o;
  elen_t       vrf_wdata_o, vrf_rdata_i;
  strb_t       vrf_wbe_o;
  logic        vrf_we_o, vrf_re_o;
  logic        vrf_wvalid_i = 1'b0;
  logic        vrf_rvalid_i = 1'b0;

  // Register file and memory as written by the DUT, and as predicted
  elen_t      vrf     [NR_VREGS*VELE];
  elen_t      exp_vrf [NR_VREGS*VELE];
  logic [7:0] mem_bytes [elen_t];
  logic [7:0] exp_mem   [elen_t];

  // Load results on their way back, in issue order
  mem_result_t pend_res[$];
  int unsigned pend_delay[$];

  vlsu_req_t   cur_req;
  int unsigned cur_bytes, cur_words, mem_base, vrf_base;
  int unsigned mem_total = 0;
  int unsigned vrf_total = 0;
  int unsigned ooo_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned stim_seed = SEED;
  int unsigned model_seed = SEED;
  mem_req_t    held_req;
  logic        held = 1'b0;

  always #5 clk_i = ~clk_i;

  vlsu i_vlsu (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .vlsu_req_i        (vlsu_req_i),
    .vlsu_req_valid_i  (vlsu_req_valid_i),
    .vlsu_req_ready_o  (vlsu_req_ready_o),
    .mem_req_o         (mem_req_o),
    .mem_valid_o       (mem_valid_o),
    .mem_ready_i       (mem_ready_i),
    .mem_result_i      (mem_result_i),
    .mem_result_valid_i(mem_result_valid_i),
    .vrf_waddr_o       (vrf_waddr_o),
    .vrf_raddr_o       (vrf_raddr_o),
    .vrf_wdata_o       (vrf_wdata_o),
    .vrf_wbe_o         (vrf_wbe_o),
    .vrf_we_o          (vrf_we_o),
    .vrf_re_o          (vrf_re_o),
    .vrf_wvalid_i      (vrf_wvalid_i),
    .vrf_rvalid_i      (vrf_rvalid_i),
    .vrf_rdata_i       (vrf_rdata_i)
  );

  // Register file read port answers in the same cycle
  assign vrf_rdata_i = vrf[vrf_raddr_o];

  ////////////////////////////////////////////////////
  // Random numbers and memory contents
  ////////////////////////////////////////////////////

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned pick(input int unsigned state, input int unsigned range);
    return (state >> 16) % range;
  endfunction

  // Untouched bytes hash the full address
  function automatic logic [7:0] fill_byte(input elen_t addr);
    elen_t h;
    h = addr * 32'h9e3779b1;
    return h[31:24] ^ addr[7:0];
  endfunction

  function automatic elen_t read_word(input logic predicted, input elen_t addr);
    elen_t w;
    elen_t a;
    for (int unsigned b = 0; b < ELENB; b++) begin
      a = addr + elen_t'(b);
      if (predicted) begin
        w[8*b +: 8] = exp_mem.exists(a) ? exp_mem[a] : fill_byte(a);
      end else begin
        w[8*b +: 8] = mem_bytes.exists(a) ? mem_bytes[a] : fill_byte(a);
      end
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////

  function automatic int unsigned ref_bytes(input vlsu_req_t req);
    case (req.vsew)
      EW_16:   return 32'(req.vl) << 1;
      EW_32:   return 32'(req.vl) << 2;
      default: return 32'(req.vl);
    endcase
  endfunction

  // Low bytes up to what is left of the operation
  function automatic strb_t ref_be(input int unsigned nbytes, input int unsigned i);
    int unsigned rem;
    rem = nbytes - ELENB * i;
    if (rem > ELENB) begin
      rem = ELENB;
    end
    return strb_t'((1 << rem) - 1);
  endfunction

  function automatic vreg_addr_t ref_vreg(input vlsu_req_t req, input int unsigned i);
    return vreg_addr_t'(32'(req.vd) * VELE + i);
  endfunction

  function automatic mem_req_t ref_mem_req(input vlsu_req_t req, input int unsigned i,
                                           input int unsigned word_cnt);
    mem_req_t r;
    int unsigned nbytes;
    nbytes  = ref_bytes(req);
    r.id    = id_t'(word_cnt);
    r.addr  = req.rs1 + elen_t'(ELENB * i);
    r.we    = req.op == VSE;
    r.size  = req.vsew;
    r.strb  = ref_be(nbytes, i);
    r.wdata = (req.op == VSE) ? exp_vrf[ref_vreg(req, i)] : '0;
    r.last  = i == (nbytes + ELENB - 1) / ELENB - 1;
    return r;
  endfunction

  // Expected register words for loads, memory bytes for stores
  function automatic void predict_op(input vlsu_req_t req, input int unsigned nbytes);
    strb_t      be;
    elen_t      addr;
    elen_t      word;
    vreg_addr_t va;
    for (int unsigned i = 0; i < (nbytes + ELENB - 1) / ELENB; i++) begin
      be   = ref_be(nbytes, i);
      addr = req.rs1 + elen_t'(ELENB * i);
      va   = ref_vreg(req, i);
      word = read_word(1'b1, addr);
      for (int unsigned b = 0; b < ELENB; b++) begin
        if (be[b] && req.op == VLE) begin
          exp_vrf[va][8*b +: 8] = word[8*b +: 8];
        end else if (be[b]) begin
          exp_mem[addr + elen_t'(b)] = exp_vrf[va][8*b +: 8];
        end
      end
    end
  endfunction

  ////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic check_elen(input string name, input elen_t act, input elen_t exp);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic check_strb(input string name, input strb_t act, input strb_t exp);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic check_vreg_addr(input string name, input vreg_addr_t act,
                                 input vreg_addr_t exp);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t act, input mem_req_t exp);
    if (act !== exp) begin
      stop_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  ////////////////////////////////////////////////////
  // Memory and register file models
  ////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    int unsigned idx;
    int unsigned k;
    mem_result_t res;
    model_seed = lcg_next(model_seed);
    mem_ready_i <= pick(model_seed, 4) != 0;
    model_seed = lcg_next(model_seed);
    vrf_wvalid_i <= pick(model_seed, 2) == 0;
    model_seed = lcg_next(model_seed);
    vrf_rvalid_i <= pick(model_seed, 3) != 0;

    // One ripe load result per cycle, any of them
    mem_result_valid_i <= 1'b0;
    foreach (pend_delay[j]) begin
      if (pend_delay[j] > 0) begin
        pend_delay[j] = pend_delay[j] - 1;
      end
    end
    if (pend_res.size() > 0) begin
      model_seed = lcg_next(model_seed);
      k = pick(model_seed, pend_res.size());
      if (pend_delay[k] == 0) begin
        mem_result_i       <= pend_res[k];
        mem_result_valid_i <= 1'b1;
        if (k != 0) begin
          ooo_cnt++;
        end
        pend_res.delete(k);
        pend_delay.delete(k);
      end
    end

    if (arst_n_i) begin
      idx = mem_total - mem_base;
      if (held && !mem_valid_o) begin
        stop_run("Memory request was withdrawn before memory accepted it");
      end else if (mem_valid_o && idx >= cur_words) begin
        stop_run("Memory request beyond the end of the operation");
      end else if (mem_valid_o) begin
        if (held) begin
          check_mem_req("mem_req_o while stalled", mem_req_o, held_req);
        end
        check_mem_req("mem_req_o", mem_req_o, ref_mem_req(cur_req, idx, mem_total));
        if (mem_ready_i) begin
          mem_total++;
          if (mem_req_o.we) begin
            for (int unsigned b = 0; b < ELENB; b++) begin
              if (mem_req_o.strb[b]) begin
                mem_bytes[mem_req_o.addr + elen_t'(b)] = mem_req_o.wdata[8*b +: 8];
              end
            end
          end else begin
            res.id    = mem_req_o.id;
            res.rdata = read_word(1'b0, mem_req_o.addr);
            pend_res.push_back(res);
            model_seed = lcg_next(model_seed);
            pend_delay.push_back(1 + pick(model_seed, 6));
          end
        end
      end
      held     = mem_valid_o && !mem_ready_i;
      held_req = mem_req_o;

      idx = vrf_total - vrf_base;
      if (vrf_we_o && vrf_wvalid_i) begin
        if (idx >= cur_words || cur_req.op != VLE) begin
          stop_run("Register file write outside a load");
        end else begin
          check_vreg_addr("vrf_waddr_o", vrf_waddr_o, ref_vreg(cur_req, idx));
          check_elen("vrf_wdata_o", vrf_wdata_o,
                     read_word(1'b1, cur_req.rs1 + elen_t'(ELENB * idx)));
          check_strb("vrf_wbe_o", vrf_wbe_o, ref_be(cur_bytes, idx));
          for (int unsigned b = 0; b < ELENB; b++) begin
            if (vrf_wbe_o[b]) begin
              vrf[vrf_waddr_o][8*b +: 8] <= vrf_wdata_o[8*b +: 8];
            end
          end
          vrf_total++;
        end
      end
      if (vrf_re_o && vrf_rvalid_i) begin
        if (idx >= cur_words || cur_req.op != VSE) begin
          stop_run("Register file read outside a store");
        end else begin
          check_vreg_addr("vrf_raddr_o", vrf_raddr_o, ref_vreg(cur_req, idx));
          vrf_total++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_run("Timeout: the operations did not complete within the cycle limit");
    end
  end

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////

  function automatic vlsu_req_t make_req(input ex_unit_e unit, input vlsu_op_e op,
                                         input logic [4:0] vd, input elen_t rs1,
                                         input vlen_t vl, input vew_e vsew);
    vlsu_req_t r;
    r.ex_unit = unit;
    r.op      = op;
    r.vd      = vd;
    r.rs1     = rs1;
    r.vl      = vl;
    r.vsew    = vsew;
    return r;
  endfunction

  task automatic run_op(input vlsu_req_t req);
    logic  active;
    elen_t addr;
    active = (req.ex_unit == LSU) && (req.vl != '0);
    @(posedge clk_i);
    cur_req   = req;
    cur_bytes = (req.ex_unit == LSU) ? ref_bytes(req) : 0;
    cur_words = (cur_bytes + ELENB - 1) / ELENB;
    mem_base  = mem_total;
    vrf_base  = vrf_total;
    predict_op(req, cur_bytes);
    vlsu_req_i       <= req;
    vlsu_req_valid_i <= 1'b1;
    @(posedge clk_i);
    check_flag("vlsu_req_ready_o", vlsu_req_ready_o, 1'b1);
    vlsu_req_valid_i <= 1'b0;
    @(posedge clk_i);
    check_flag("vlsu_req_ready_o", vlsu_req_ready_o, !active);
    while (!vlsu_req_ready_o) begin
      @(posedge clk_i);
    end
    // Nothing may move once the unit is idle
    repeat (3) begin
      @(posedge clk_i);
      check_flag("vlsu_req_ready_o", vlsu_req_ready_o, 1'b1);
      check_flag("mem_valid_o", mem_valid_o, 1'b0);
    end
    if (mem_total - mem_base != cur_words || vrf_total - vrf_base != cur_words) begin
      stop_run("Wrong number of memory or register file transfers in an operation");
    end
    for (int unsigned i = 0; i < cur_words; i++) begin
      addr = req.rs1 + elen_t'(ELENB * i);
      check_elen("vrf word", vrf[ref_vreg(req, i)], exp_vrf[ref_vreg(req, i)]);
      check_elen("memory word", read_word(1'b0, addr), read_word(1'b1, addr));
    end
  endtask

  initial begin
    vlsu_req_t req;
    int unsigned max_vl;
    arst_n_i         <= 1'b0;
    vlsu_req_i       <= '0;
    vlsu_req_valid_i <= 1'b0;
    for (int unsigned k = 0; k < NR_VREGS * VELE; k++) begin
      exp_vrf[k] = 32'hc0de0000 ^ (k * 32'h01000193);
      vrf[k]    <= 32'hc0de0000 ^ (k * 32'h01000193);
    end
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    check_flag("vlsu_req_ready_o", vlsu_req_ready_o, 1'b1);
    check_flag("mem_valid_o", mem_valid_o, 1'b0);
    check_flag("vrf_we_o", vrf_we_o, 1'b0);
    check_flag("vrf_re_o", vrf_re_o, 1'b0);

    // Full words, then partial last words
    run_op(make_req(LSU, VLE, 5'd3, 32'h1000, 6'd8, EW_32));
    run_op(make_req(LSU, VSE, 5'd3, 32'h2000, 6'd8, EW_32));
    run_op(make_req(LSU, VLE, 5'd4, 32'h2000, 6'd7, EW_8));
    run_op(make_req(LSU, VSE, 5'd6, 32'h3000, 6'd5, EW_16));
    run_op(make_req(LSU, VSE, 5'd7, 32'h3100, 6'd13, EW_8));
    run_op(make_req(LSU, VLE, 5'd8, 32'h3000, 6'd3, EW_16));
    // Empty and foreign requests
    run_op(make_req(LSU, VLE, 5'd9, 32'h1000, 6'd0, EW_32));
    run_op(make_req(ALU, VSE, 5'd9, 32'h1000, 6'd8, EW_32));

    for (int unsigned n = 0; n < NUM_RANDOM_OPS; n++) begin
      stim_seed = lcg_next(stim_seed);
      req.ex_unit = LSU;
      req.op      = (pick(stim_seed, 2) == 0) ? VLE : VSE;
      stim_seed = lcg_next(stim_seed);
      case (pick(stim_seed, 3))
        0:       req.vsew = EW_8;
        1:       req.vsew = EW_16;
        default: req.vsew = EW_32;
      endcase
      max_vl = 32 >> req.vsew;
      stim_seed = lcg_next(stim_seed);
      req.vl = vlen_t'(1 + pick(stim_seed, max_vl));
      stim_seed = lcg_next(stim_seed);
      req.vd = 5'(pick(stim_seed, NR_VREGS));
      stim_seed = lcg_next(stim_seed);
      req.rs1 = 32'h4000 + elen_t'(ELENB * pick(stim_seed, 64));
      run_op(req);
    end

    if (ooo_cnt == 0) begin
      stop_run("No load result came back out of order");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: vlsu.f
rtl/vlsu_pkg.sv
rtl/vlsu_req_ctrl.sv
rtl/vlsu_byte_counter.sv
rtl/vlsu_reorder_buffer.sv
rtl/vlsu_datapath.sv
rtl/vlsu.sv
sim/tb_vlsu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vlsu
FILELIST  ?= vlsu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR)
